//--- Makefile
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= tb_cache
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build and run the simulation, then check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/cache_ctrl_fsm.sv
// Cache controller FSM
// Sequences lookup, write-through, refill and the processor response

`timescale 1ns/1ps

module cache_ctrl_fsm import cache_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  cpu_req_t    cpu_req,
  input  logic        hit,
  input  logic        credit_avail,
  input  logic        last_beat,
  input  logic        beat_valid,
  output logic        cpu_ready,
  output logic        cpu_rsp_valid,
  output logic        rsp_hit,
  output mem_req_t    mem_req,
  output logic        credit_take,
  output cache_addr_u lookup_addr,
  output logic        word_write,
  output logic        line_fill,
  output logic        count_clear
);

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITE_THRU,
    REFILL_REQ,
    REFILL_WAIT,
    RESPOND
  } state_t;

  state_t      state;
  state_t      state_next;
  cpu_req_t    req_q;                                         // Request being served
  logic        hit_q;
  logic        rsp_valid_q;
  cache_addr_u mem_addr;
  logic        send_req;

  // **************************************************
  // Next state
  // **************************************************
  always_comb begin
    state_next = state;
    case (state)
      IDLE:        if (cpu_req.valid) state_next = LOOKUP;
      LOOKUP: begin
        if (req_q.write) state_next = WRITE_THRU;              // Writes always go to memory
        else if (hit) state_next = RESPOND;
        else state_next = REFILL_REQ;
      end
      WRITE_THRU:  if (credit_avail) state_next = IDLE;
      REFILL_REQ:  if (credit_avail) state_next = REFILL_WAIT;
      REFILL_WAIT: if (beat_valid && last_beat) state_next = RESPOND;
      RESPOND:     state_next = IDLE;
      default:     state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      hit_q       <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      state       <= state_next;
      rsp_valid_q <= (state == RESPOND) || (state == WRITE_THRU && credit_avail);
      if (state == LOOKUP) hit_q <= hit;
    end
  end

  // Request payload is captured only when a new request is taken
  always_ff @(posedge clk) begin
    if (cpu_ready && cpu_req.valid) req_q <= cpu_req;
  end

  // **************************************************
  // Memory request
  // **************************************************
  always_comb begin
    mem_addr                 = req_q.addr;
    mem_addr.fields.byte_off = '0;
    if (!req_q.write) mem_addr.fields.offset = '0;            // Refill fetches the whole line
  end

  assign send_req = (state == WRITE_THRU || state == REFILL_REQ) && credit_avail;

  assign mem_req.valid = send_req;
  assign mem_req.write = req_q.write;
  assign mem_req.addr  = mem_addr.raw;
  assign mem_req.wdata = req_q.wdata;
  assign credit_take   = send_req;

  // Store and counter controls
  assign cpu_ready     = (state == IDLE);
  assign cpu_rsp_valid = rsp_valid_q;
  assign rsp_hit       = hit_q;
  assign lookup_addr   = req_q.addr;
  assign word_write    = (state == LOOKUP) && req_q.write && hit;
  assign line_fill     = (state == REFILL_WAIT);
  assign count_clear   = (state == REFILL_REQ);

endmodule

//--- hw/cache_line_store.sv
// Cache line store
// Valid, tag and data arrays with hit check, word access and refill

`timescale 1ns/1ps

module cache_line_store import cache_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  cache_addr_u         lookup_addr,
  input  logic                word_write,
  input  logic [WORD_W-1:0]   wdata,
  input  logic                line_fill,
  input  mem_rsp_t            fill_beat,
  input  logic [OFFSET_W-1:0] beat_slot,
  output logic                hit,
  output logic [WORD_W-1:0]   rd_word
);

  logic [NUM_LINES-1:0] valid_bits;
  logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
  logic [WORD_W-1:0]    data_mem [NUM_LINES][LINE_WORDS];

  logic [INDEX_W-1:0]  idx;
  logic [OFFSET_W-1:0] off;
  logic [TAG_W-1:0]    tag;
  logic                fill_we;
  logic                fill_last;

  assign idx = lookup_addr.fields.index;
  assign off = lookup_addr.fields.offset;
  assign tag = lookup_addr.fields.tag;

  assign fill_we   = line_fill && fill_beat.valid;
  assign fill_last = fill_we && (beat_slot == OFFSET_W'(LINE_WORDS - 1));

  // **************************************************
  // Lookup
  // **************************************************
  assign hit     = valid_bits[idx] && (tag_mem[idx] == tag);
  assign rd_word = data_mem[idx][off];                         // Read is combinational

  // **************************************************
  // Updates
  // **************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_bits <= '0;                                       // All lines start invalid
    end else if (fill_last) begin
      valid_bits[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_we) begin
      data_mem[idx][beat_slot] <= fill_beat.data;
    end else if (word_write) begin
      data_mem[idx][off] <= wdata;                            // Write hit updates one word
    end
  end

  // Tag goes in with the last beat so a partial line never hits
  always_ff @(posedge clk) begin
    if (fill_last) tag_mem[idx] <= tag;
  end

endmodule

//--- hw/cache_pkg.sv
// Shared definitions for the direct-mapped write-through cache
// Address split, processor port and memory port types

package cache_pkg;

  // **************************************************
  // Widths and sizes
  // **************************************************
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int LINE_WORDS = 8;
  localparam int NUM_LINES  = 64;
  localparam int BYTE_W     = 2;                              // Byte select bits in a word
  localparam int OFFSET_W   = $clog2(LINE_WORDS);
  localparam int INDEX_W    = $clog2(NUM_LINES);
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W - BYTE_W;

  // **************************************************
  // Address, seen as one word or as its fields
  // **************************************************
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;                              // Word within the line
    logic [BYTE_W-1:0]   byte_off;
  } cache_addr_fields_t;

  typedef union packed {
    logic [ADDR_W-1:0]  raw;
    cache_addr_fields_t fields;
  } cache_addr_u;

  // **************************************************
  // Port bundles
  // **************************************************
  typedef struct packed {
    logic              valid;
    logic              write;
    cache_addr_u       addr;
    logic [WORD_W-1:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic              valid;
    logic              hit;
    logic [WORD_W-1:0] rdata;
  } cpu_rsp_t;

  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] addr;                                  // Line aligned for reads
    logic [WORD_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] data;                                  // One refill beat
  } mem_rsp_t;

endpackage

//--- hw/cache_top.sv
// Direct-mapped write-through cache
// Joins the controller, line store and counters to the CPU and memory ports

`timescale 1ns/1ps

module cache_top import cache_pkg::*; #(
  parameter int MEM_CREDITS = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  cpu_req_t cpu_req,
  input  logic     mem_credit,
  input  mem_rsp_t mem_rsp,
  output logic     cpu_ready,
  output cpu_rsp_t cpu_rsp,
  output mem_req_t mem_req
);

  logic                hit;
  logic [WORD_W-1:0]   rd_word;
  logic                credit_avail;
  logic                credit_take;
  logic                last_beat;
  logic [OFFSET_W-1:0] beat_slot;
  logic                cpu_rsp_valid;
  logic                rsp_hit;
  cache_addr_u         lookup_addr;
  logic                word_write;
  logic                line_fill;
  logic                count_clear;

  // **************************************************
  // Controller
  // **************************************************
  cache_ctrl_fsm i_cache_ctrl_fsm (
    .clk           (clk),
    .rst           (rst),
    .cpu_req       (cpu_req),
    .hit           (hit),
    .credit_avail  (credit_avail),
    .last_beat     (last_beat),
    .beat_valid    (mem_rsp.valid),
    .cpu_ready     (cpu_ready),
    .cpu_rsp_valid (cpu_rsp_valid),
    .rsp_hit       (rsp_hit),
    .mem_req       (mem_req),
    .credit_take   (credit_take),
    .lookup_addr   (lookup_addr),
    .word_write    (word_write),
    .line_fill     (line_fill),
    .count_clear   (count_clear)
  );

  // **************************************************
  // Datapath
  // **************************************************
  cache_line_store i_cache_line_store (
    .clk         (clk),
    .rst         (rst),
    .lookup_addr (lookup_addr),
    .word_write  (word_write),
    .wdata       (mem_req.wdata),                              // Latched write data
    .line_fill   (line_fill),
    .fill_beat   (mem_rsp),
    .beat_slot   (beat_slot),
    .hit         (hit),
    .rd_word     (rd_word)
  );

  refill_beat_counter i_refill_beat_counter (
    .clk         (clk),
    .rst         (rst),
    .count_clear (count_clear),
    .beat_valid  (mem_rsp.valid),
    .beat_slot   (beat_slot),
    .last_beat   (last_beat)
  );

  mem_credit_counter #(
    .MEM_CREDITS (MEM_CREDITS)
  ) i_mem_credit_counter (
    .clk           (clk),
    .rst           (rst),
    .credit_take   (credit_take),
    .credit_return (mem_credit),
    .credit_avail  (credit_avail)
  );

  // Read data stays valid since the lookup address is held until the next request
  assign cpu_rsp.valid = cpu_rsp_valid;
  assign cpu_rsp.hit   = rsp_hit;
  assign cpu_rsp.rdata = rd_word;

endmodule

//--- hw/mem_credit_counter.sv
// Memory request credit counter
// Starts full, spends one per request and regains one per returned credit

`timescale 1ns/1ps

module mem_credit_counter #(
  parameter int MEM_CREDITS = 2
) (
  input  logic clk,
  input  logic rst,
  input  logic credit_take,
  input  logic credit_return,
  output logic credit_avail
);

  localparam int CNT_W = $clog2(MEM_CREDITS + 1);

  logic [CNT_W-1:0] credits;

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CNT_W'(MEM_CREDITS);
    end else begin
      case ({credit_take, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;                          // Take and return cancel out
      endcase
    end
  end

  assign credit_avail = (credits != '0);

endmodule

//--- hw/refill_beat_counter.sv
// Refill beat counter
// Gives the line slot of each incoming beat and flags the final one

`timescale 1ns/1ps

module refill_beat_counter import cache_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                count_clear,
  input  logic                beat_valid,
  output logic [OFFSET_W-1:0] beat_slot,
  output logic                last_beat
);

  logic [OFFSET_W-1:0] count;

  // **************************************************
  // Beat count
  // **************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (count_clear) begin
      count <= '0;                                            // Restart before each refill
    end else if (beat_valid) begin
      count <= count + 1'b1;                                  // Wraps after the last slot
    end
  end

  // Beats arrive in offset order, so the count is the slot
  assign beat_slot = count;
  assign last_beat = (count == OFFSET_W'(LINE_WORDS - 1));

endmodule

//--- tests/mem_model.sv
// Memory model for the cache testbench
// Refills lines, stores write-through data and returns request credits

`timescale 1ns/1ps

module mem_model import cache_pkg::*; #(
  parameter int MEM_CREDITS = 2,
  parameter int MEM_WORDS   = 4096
) (
  input  logic     clk,
  input  logic     rst,
  input  mem_req_t mem_req,
  output logic     mem_credit,
  output mem_rsp_t mem_rsp,
  output logic     credit_overrun
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [WORD_W-1:0] mem [MEM_WORDS];
  int unsigned       credit_due_q[$];                         // Cycle at which each credit is due
  int unsigned       cycle;
  int                owed;                                    // Requests not yet credited back
  int                beats_left;
  int unsigned       beat_wait;
  logic [AW-1:0]     beat_addr;
  logic [AW-1:0]     req_word;

  logic     credit_q  = 1'b0;
  mem_rsp_t rsp_q     = '0;
  logic     overrun_q = 1'b0;

  assign mem_credit     = credit_q;
  assign mem_rsp        = rsp_q;
  assign credit_overrun = overrun_q;
  assign req_word       = mem_req.addr[AW+1:2];

  // **************************************************
  // Cycle behavior
  // **************************************************
  always @(posedge clk) begin
    if (rst) begin
      credit_q   <= 1'b0;
      rsp_q      <= '0;
      overrun_q  <= 1'b0;
      credit_due_q.delete();
      cycle      = 0;
      owed       = 0;
      beats_left = 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] = i ^ 32'h5A5A0000;                            // Fill pattern from the word address
      end
    end else begin
      cycle = cycle + 1;

      // At most one credit per cycle, oldest request first
      credit_q <= 1'b0;
      if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle) begin
        void'(credit_due_q.pop_front());
        credit_q <= 1'b1;
        owed = owed - 1;
      end

      rsp_q.valid <= 1'b0;
      if (beats_left > 0) begin
        if (beat_wait > 0) begin
          beat_wait = beat_wait - 1;                          // Refill start delay
        end else begin
          rsp_q.valid <= 1'b1;
          rsp_q.data  <= mem[beat_addr];
          beat_addr  = beat_addr + 1'b1;
          beats_left = beats_left - 1;
        end
      end

      if (mem_req.valid) begin
        if (owed >= MEM_CREDITS) overrun_q <= 1'b1;           // Request arrived with no buffer free
        owed = owed + 1;
        credit_due_q.push_back(cycle + $urandom_range(5, 0));
        if (mem_req.write) begin
          mem[req_word] = mem_req.wdata;
        end else begin
          beat_addr  = req_word;                              // Line aligned by the cache
          beats_left = LINE_WORDS;
          beat_wait  = $urandom_range(3, 0);
        end
      end
    end
  end

endmodule

//--- tests/tb_cache.sv
// Testbench for the direct-mapped write-through cache
// Directed and random traffic checked against a shadow memory and tag table

`timescale 1ns/1ps

module tb_cache import cache_pkg::*; ();

  localparam int MEM_CREDITS  = 1;                            // Back to back writes stall on it
  localparam int MEM_WORDS    = 4096;
  localparam int WORD_AW      = $clog2(MEM_WORDS);
  localparam int NUM_DIRECTED = 10;
  localparam int NUM_BURST    = 40;
  localparam int NUM_RANDOM   = 300;
  localparam int NUM_OPS      = NUM_DIRECTED + NUM_BURST + NUM_RANDOM + 1;
  localparam int SEED         = 56523;

  logic     clk;
  logic     rst;
  cpu_req_t cpu_req;
  logic     cpu_ready;
  cpu_rsp_t cpu_rsp;
  mem_req_t mem_req;
  logic     mem_credit;
  mem_rsp_t mem_rsp;
  logic     credit_overrun;

  logic [WORD_W-1:0]    shadow_mem [MEM_WORDS];
  logic [TAG_W-1:0]     shadow_tag [NUM_LINES];
  logic [NUM_LINES-1:0] shadow_valid;
  mem_req_t             exp_req_q[$];                         // Memory requests still to be seen
  int                   outstanding;

  cache_top #(.MEM_CREDITS(MEM_CREDITS)) i_cache_top (
    .clk        (clk),
    .rst        (rst),
    .cpu_req    (cpu_req),
    .mem_credit (mem_credit),
    .mem_rsp    (mem_rsp),
    .cpu_ready  (cpu_ready),
    .cpu_rsp    (cpu_rsp),
    .mem_req    (mem_req)
  );

  mem_model #(.MEM_CREDITS(MEM_CREDITS), .MEM_WORDS(MEM_WORDS)) i_mem_model (
    .clk            (clk),
    .rst            (rst),
    .mem_req        (mem_req),
    .mem_credit     (mem_credit),
    .mem_rsp        (mem_rsp),
    .credit_overrun (credit_overrun)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(NUM_OPS * (LINE_WORDS + 20) * 10);
    $display("Timeout: the cache stopped making progress before all operations ended");
    $display("Done: errors found");
    $fatal(1, "Watchdog expired");
  end

  task automatic fail_check(input string what);
    $display("Error: time %0d ns: %s", $time, what);
    $display("Done: errors found");
    $fatal(1, "Check failed");
  endtask

  // **************************************************
  // Memory port monitor
  // **************************************************
  always @(posedge clk) begin : req_monitor
    int       next_out;
    mem_req_t exp;
    if (rst) begin
      outstanding = 0;
    end else begin
      next_out = outstanding + int'(mem_req.valid) - int'(mem_credit);
      assert (next_out >= 0 && next_out <= MEM_CREDITS)
        else fail_check($sformatf("%0d requests in flight at memory", next_out));
      assert (!credit_overrun) else fail_check("memory got a request with no credit left");
      outstanding = next_out;
      if (mem_req.valid) begin
        assert (exp_req_q.size() > 0) else fail_check("unexpected memory request");
        exp = exp_req_q.pop_front();
        assert (mem_req.write == exp.write && mem_req.addr == exp.addr &&
                (!exp.write || mem_req.wdata == exp.wdata))
          else fail_check($sformatf("mem request w=%0b %h/%h, expected w=%0b %h/%h",
                                    mem_req.write, mem_req.addr, mem_req.wdata,
                                    exp.write, exp.addr, exp.wdata));
      end
    end
  end

  // One processor access is predicted from the shadow state and then checked
  task automatic cpu_access(input logic write, input logic [ADDR_W-1:0] addr,
                            input logic [WORD_W-1:0] wdata);
    cache_addr_u        a;
    cpu_req_t           req;
    mem_req_t           exp;
    logic [WORD_AW-1:0] word;
    logic [WORD_W-1:0]  exp_data;
    logic               exp_hit;
    int                 waited;
    a.raw    = addr;
    word     = addr[WORD_AW+1:2];
    exp_hit  = shadow_valid[a.fields.index] && (shadow_tag[a.fields.index] == a.fields.tag);
    exp_data = shadow_mem[word];
    exp.valid = 1'b1;
    exp.write = write;
    exp.wdata = wdata;
    if (write) begin
      shadow_mem[word] = wdata;                               // No allocate on a write miss
      exp.addr = {addr[ADDR_W-1:2], 2'b00};
      exp_req_q.push_back(exp);
    end else if (!exp_hit) begin
      shadow_valid[a.fields.index] = 1'b1;
      shadow_tag[a.fields.index]   = a.fields.tag;
      exp.addr = {addr[ADDR_W-1:OFFSET_W+2], {(OFFSET_W+2){1'b0}}};
      exp_req_q.push_back(exp);
    end
    req.valid = 1'b1;
    req.write = write;
    req.addr  = a;
    req.wdata = wdata;
    cpu_req <= req;
    do @(posedge clk); while (!cpu_ready);
    cpu_req.valid <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      assert (waited <= LINE_WORDS + 20) else fail_check("the cache gave no response");
    end while (!cpu_rsp.valid);
    assert (cpu_rsp.hit == exp_hit)
      else fail_check($sformatf("hit %0b at %h, expected %0b", cpu_rsp.hit, addr, exp_hit));
    if (!write) begin
      assert (cpu_rsp.rdata == exp_data)
        else fail_check($sformatf("read %h at %h, expected %h", cpu_rsp.rdata, addr, exp_data));
    end
    if (!write && exp_hit) begin
      assert (waited == 3)
        else fail_check($sformatf("read hit took %0d cycles, expected 2", waited - 1));
    end
  endtask

  function automatic logic [ADDR_W-1:0] random_addr();
    logic [31:0] r;
    r = $urandom();
    if (r[31]) r[13:11] = 3'b000;                             // Half the traffic fits the cache
    return {18'b0, r[13:2], 2'b00};
  endfunction

  // **************************************************
  // Stimulus
  // **************************************************
  initial begin
    logic [ADDR_W-1:0] a0;
    logic [ADDR_W-1:0] a1;
    logic [31:0]       r;
    void'($urandom(SEED));
    cpu_req <= '0;
    rst     <= 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) shadow_mem[i] = i ^ 32'h5A5A0000;
    shadow_valid = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (cpu_ready && !cpu_rsp.valid && !mem_req.valid)
      else fail_check("port state after reset is wrong");

    cpu_access(1'b0, 32'h0000_0104, '0);                     // Miss then hit on the same line
    cpu_access(1'b0, 32'h0000_0104, '0);
    cpu_access(1'b1, 32'h0000_0108, 32'hCAFE_0001);           // Write hit
    cpu_access(1'b0, 32'h0000_0108, '0);
    cpu_access(1'b1, 32'h0000_2210, 32'hBEEF_0002);           // Write miss without allocation
    cpu_access(1'b0, 32'h0000_2210, '0);
    a0 = 32'h0000_0340;
    a1 = a0 + 32'h0000_0800;                                  // Same index with the next tag
    repeat (2) begin
      cpu_access(1'b0, a0, '0);
      cpu_access(1'b0, a1, '0);
    end

    // Back to back writes keep the credits in use
    repeat (NUM_BURST) cpu_access(1'b1, random_addr(), $urandom());

    repeat (NUM_RANDOM) begin
      r = $urandom();
      cpu_access(r[0], random_addr(), $urandom());
    end

    @(posedge clk);
    assert (exp_req_q.size() == 0) else fail_check("memory requests are missing");
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- verilog.f
hw/cache_pkg.sv
hw/cache_ctrl_fsm.sv
hw/cache_line_store.sv
hw/refill_beat_counter.sv
hw/mem_credit_counter.sv
hw/cache_top.sv
tests/mem_model.sv
tests/tb_cache.sv
